// File: fedp_pkg.sv
package fedp_pkg;

    // ########################################################
    // Datapath widths.
    // ########################################################
    localparam int NUM_LANES = 4;           // Masked vector lanes.
    localparam int NUM_TERMS = NUM_LANES + 1; // Lanes plus C term.
    localparam int OP_W      = 8;           // A and B significands.
    localparam int EXP_W     = 4;           // Lane exponents.
    localparam int CEXP_W    = 5;           // Product and C exponents.
    localparam int PROD_W    = 16;          // Products and C.
    localparam int GUARD_W   = 8;           // Zero bits below each term.
    localparam int SIG_W     = 26;          // Aligned term.
    localparam int ACC_W     = 30;          // Accumulated sum.

    // ########################################################
    // Register map.
    // ########################################################
    localparam int AXI_ADDR_W = 4;
    localparam int AXI_DATA_W = 32;

    localparam logic [AXI_ADDR_W-1:0] ADDR_CTRL  = 4'h0; // Enable, lane mask.
    localparam logic [AXI_ADDR_W-1:0] ADDR_COUNT = 4'h4; // Result counter, RO.
    localparam logic [AXI_DATA_W-1:0] CTRL_RESET = 32'h0000_00F1; // On, all lanes.

    // Incoming request, one dot product.
    typedef struct packed {
        logic [NUM_LANES-1:0][OP_W-1:0]  a;     // Signed.
        logic [NUM_LANES-1:0][OP_W-1:0]  b;     // Signed.
        logic [NUM_LANES-1:0][EXP_W-1:0] a_exp;
        logic [NUM_LANES-1:0][EXP_W-1:0] b_exp;
        logic [PROD_W-1:0]               c;     // Signed.
        logic [CEXP_W-1:0]               c_exp;
    } fedp_req_t;

    // Multiply stage output. Term NUM_LANES is C.
    typedef struct packed {
        logic                              valid;
        logic [NUM_TERMS-1:0][PROD_W-1:0]  term;  // Signed values.
        logic [NUM_TERMS-1:0][CEXP_W-1:0]  exp;
        logic [NUM_LANES-1:0]              lane_mask;
    } fedp_prod_t;

    // Align stage output.
    typedef struct packed {
        logic                             valid;
        logic [NUM_TERMS-1:0][SIG_W-1:0]  sig;   // Signed, aligned.
        logic [NUM_TERMS-1:0]             sticky;
        logic [CEXP_W-1:0]                max_exp;
        logic [NUM_LANES-1:0]             lane_mask;
    } fedp_aln_t;

    // Final result.
    typedef struct packed {
        logic signed [ACC_W-1:0] sig;
        logic                    sticky;
        logic [CEXP_W-1:0]       exp;
    } fedp_res_t;

    // AXI4-Lite, master to slave.
    typedef struct packed {
        logic                    awvalid;
        logic [AXI_ADDR_W-1:0]   awaddr;
        logic                    wvalid;
        logic [AXI_DATA_W-1:0]   wdata;
        logic [AXI_DATA_W/8-1:0] wstrb;
        logic                    bready;
        logic                    arvalid;
        logic [AXI_ADDR_W-1:0]   araddr;
        logic                    rready;
    } axil_req_t;

    // AXI4-Lite, slave to master.
    typedef struct packed {
        logic                  awready;
        logic                  wready;
        logic                  bvalid;
        logic [1:0]            bresp;
        logic                  arready;
        logic                  rvalid;
        logic [AXI_DATA_W-1:0] rdata;
        logic [1:0]            rresp;
    } axil_rsp_t;

endpackage

// File: fedp_csr.sv
module fedp_csr (
    input  logic                               clk,
    input  logic                               arst_n,
    input  fedp_pkg::axil_req_t                axil_req,
    output fedp_pkg::axil_rsp_t                axil_rsp,
    input  logic                               result_done,
    output logic                               enable,
    output logic [fedp_pkg::NUM_LANES-1:0]     lane_mask
);

    logic                              awready_q;   // Drives awready and wready.
    logic                              bvalid_q;
    logic                              arready_q;
    logic                              rvalid_q;
    logic [fedp_pkg::AXI_DATA_W-1:0]   rdata_q;
    logic [fedp_pkg::AXI_DATA_W-1:0]   rdata_d;
    logic                              enable_q;
    logic [fedp_pkg::NUM_LANES-1:0]    mask_q;
    logic [fedp_pkg::AXI_DATA_W-1:0]   count_q;
    logic [fedp_pkg::AXI_DATA_W-1:0]   ctrl_word;
    logic                              wr_hs;
    logic                              rd_hs;

    // ########################################################
    // Handshakes.
    // ########################################################
    // Address and data accepted in the same beat.
    assign wr_hs = awready_q && axil_req.awvalid && axil_req.wvalid;
    assign rd_hs = arready_q && axil_req.arvalid;

    // CTRL layout: enable at bit 0, mask at 7:4.
    assign ctrl_word = {{(fedp_pkg::AXI_DATA_W-8){1'b0}}, mask_q, 3'b000, enable_q};

    // Read mux.
    always_comb begin
        case (axil_req.araddr)
            fedp_pkg::ADDR_CTRL:  rdata_d = ctrl_word;
            fedp_pkg::ADDR_COUNT: rdata_d = count_q;
            default:              rdata_d = '0;   // Unmapped.
        endcase
    end

    // Write channel.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            awready_q <= 1'b0;
            bvalid_q  <= 1'b0;
        end else begin
            // One-cycle ready pulse, blocked while a response waits.
            awready_q <= axil_req.awvalid && axil_req.wvalid && !bvalid_q && !awready_q;
            if (wr_hs) begin
                bvalid_q <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;   // Response taken.
            end
        end
    end

    // Read channel.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            arready_q <= axil_req.arvalid && !rvalid_q && !arready_q;
            if (rd_hs) begin
                rvalid_q <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // Read data, captured at the address beat.
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata_q <= rdata_d;
        end
    end

    // ########################################################
    // Control fields and result counter.
    // ########################################################
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enable_q <= fedp_pkg::CTRL_RESET[0];
            mask_q   <= fedp_pkg::CTRL_RESET[7:4];
        end else if (wr_hs && axil_req.awaddr == fedp_pkg::ADDR_CTRL && axil_req.wstrb[0]) begin
            enable_q <= axil_req.wdata[0];
            mask_q   <= axil_req.wdata[7:4];
        end
    end

    // Wraps at 2^32; writes to COUNT are dropped.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count_q <= '0;
        end else if (result_done) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Outputs.
    assign enable    = enable_q;
    assign lane_mask = mask_q;

    assign axil_rsp = '{
        awready: awready_q,
        wready:  awready_q,
        bvalid:  bvalid_q,
        bresp:   2'b00,       // OKAY.
        arready: arready_q,
        rvalid:  rvalid_q,
        rdata:   rdata_q,
        rresp:   2'b00
    };

endmodule

// File: fedp_mul.sv
module fedp_mul (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            valid_in,
    input  fedp_pkg::fedp_req_t             req,
    input  logic                            enable,
    input  logic [fedp_pkg::NUM_LANES-1:0]  lane_mask,
    output fedp_pkg::fedp_prod_t            prod
);

    logic                                                     valid_q;
    logic [fedp_pkg::NUM_TERMS-1:0][fedp_pkg::PROD_W-1:0]     term_q;
    logic [fedp_pkg::NUM_TERMS-1:0][fedp_pkg::CEXP_W-1:0]     exp_q;
    logic [fedp_pkg::NUM_LANES-1:0]                           mask_q;

    // Disabled requests die here.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_in && enable;
        end
    end

    // ########################################################
    // Products and exponent sums.
    // ########################################################
    always_ff @(posedge clk) begin
        for (int i = 0; i < fedp_pkg::NUM_LANES; i++) begin
            // 8x8 signed fits in 16, even -128 * -128.
            term_q[i] <= $signed(req.a[i]) * $signed(req.b[i]);
            exp_q[i]  <= req.a_exp[i] + req.b_exp[i];  // 5-bit sum.
        end
        // C takes the last slot as is.
        term_q[fedp_pkg::NUM_LANES] <= req.c;
        exp_q[fedp_pkg::NUM_LANES]  <= req.c_exp;
        // Mask rides along with the item.
        mask_q <= lane_mask;
    end

    assign prod = '{
        valid:     valid_q,
        term:      term_q,
        exp:       exp_q,
        lane_mask: mask_q
    };

endmodule

// File: fedp_align.sv
module fedp_align (
    input  logic                  clk,
    input  logic                  arst_n,
    input  fedp_pkg::fedp_prod_t  prod,
    output fedp_pkg::fedp_aln_t   aln
);

    logic [fedp_pkg::CEXP_W-1:0]                              max_exp;
    logic [fedp_pkg::NUM_TERMS-1:0][fedp_pkg::CEXP_W-1:0]     diff;
    logic [fedp_pkg::NUM_TERMS-1:0][fedp_pkg::SIG_W-1:0]      placed;
    logic [fedp_pkg::NUM_TERMS-1:0][fedp_pkg::SIG_W-1:0]      shifted;
    logic [fedp_pkg::NUM_TERMS-1:0]                           sticky;

    logic                                                     valid_q;
    logic [fedp_pkg::NUM_TERMS-1:0][fedp_pkg::SIG_W-1:0]      sig_q;
    logic [fedp_pkg::NUM_TERMS-1:0]                           sticky_q;
    logic [fedp_pkg::CEXP_W-1:0]                              max_q;
    logic [fedp_pkg::NUM_LANES-1:0]                           mask_q;

    // Largest exponent, masked lanes included.
    always_comb begin
        max_exp = prod.exp[0];
        for (int i = 1; i < fedp_pkg::NUM_TERMS; i++) begin
            if (prod.exp[i] > max_exp) begin
                max_exp = prod.exp[i];
            end
        end
    end

    // ########################################################
    // Per-term shift and sticky.
    // ########################################################
    always_comb begin
        for (int i = 0; i < fedp_pkg::NUM_TERMS; i++) begin
            diff[i] = max_exp - prod.exp[i];
            // Sign bits on top, guard zeros below.
            placed[i] = {{(fedp_pkg::SIG_W - fedp_pkg::PROD_W - fedp_pkg::GUARD_W)
                          {prod.term[i][fedp_pkg::PROD_W-1]}},
                         prod.term[i], {fedp_pkg::GUARD_W{1'b0}}};
            if (diff[i] >= fedp_pkg::SIG_W) begin
                // Fully shifted out.
                shifted[i] = {fedp_pkg::SIG_W{placed[i][fedp_pkg::SIG_W-1]}};
                sticky[i]  = |placed[i];
            end else begin
                shifted[i] = $signed(placed[i]) >>> diff[i];
                // Bits below the shift point.
                sticky[i]  = |(placed[i] & ~({fedp_pkg::SIG_W{1'b1}} << diff[i]));
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= prod.valid;
        end
    end

    always_ff @(posedge clk) begin
        sig_q    <= shifted;
        sticky_q <= sticky;
        max_q    <= max_exp;
        mask_q   <= prod.lane_mask;   // Still travels with item.
    end

    assign aln = '{
        valid:     valid_q,
        sig:       sig_q,
        sticky:    sticky_q,
        max_exp:   max_q,
        lane_mask: mask_q
    };

endmodule

// File: fedp_acc.sv
module fedp_acc (
    input  logic                 clk,
    input  logic                 arst_n,
    input  fedp_pkg::fedp_aln_t  aln,
    output logic                 valid_out,
    output fedp_pkg::fedp_res_t  res
);

    logic [fedp_pkg::NUM_TERMS-1:0][fedp_pkg::SIG_W-1:0]  sig_m;
    logic [fedp_pkg::NUM_TERMS-1:0]                       sticky_m;
    logic [fedp_pkg::NUM_TERMS-1:0][fedp_pkg::ACC_W-1:0]  ext;
    logic [fedp_pkg::ACC_W-1:0]                           s1, c1, s2, c2, s3, c3;
    logic [fedp_pkg::ACC_W-1:0]                           sum;

    // 3:2 compressor. Carry out of the top bit is dropped (mod 2^ACC_W).
    function automatic void csa3(
        input  logic [fedp_pkg::ACC_W-1:0] x,
        input  logic [fedp_pkg::ACC_W-1:0] y,
        input  logic [fedp_pkg::ACC_W-1:0] z,
        output logic [fedp_pkg::ACC_W-1:0] s,
        output logic [fedp_pkg::ACC_W-1:0] c
    );
        s = x ^ y ^ z;
        c = ((x & y) | (x & z) | (y & z)) << 1;
    endfunction

    // ########################################################
    // Lane masking and sign extension.
    // ########################################################
    always_comb begin
        for (int i = 0; i < fedp_pkg::NUM_LANES; i++) begin
            sig_m[i]    = aln.lane_mask[i] ? aln.sig[i] : '0;
            sticky_m[i] = aln.sticky[i] & aln.lane_mask[i];
        end
        // C is never masked.
        sig_m[fedp_pkg::NUM_LANES]    = aln.sig[fedp_pkg::NUM_LANES];
        sticky_m[fedp_pkg::NUM_LANES] = aln.sticky[fedp_pkg::NUM_LANES];
        for (int i = 0; i < fedp_pkg::NUM_TERMS; i++) begin
            ext[i] = {{(fedp_pkg::ACC_W - fedp_pkg::SIG_W){sig_m[i][fedp_pkg::SIG_W-1]}},
                      sig_m[i]};
        end
    end

    // ########################################################
    // Carry-save tree, five terms down to two.
    // ########################################################
    always_comb begin
        csa3(ext[0], ext[1], ext[2], s1, c1);
        csa3(s1, c1, ext[3], s2, c2);
        csa3(s2, c2, ext[4], s3, c3);
        sum = s3 + c3;   // Final carry-propagate add.
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= aln.valid;
        end
    end

    always_ff @(posedge clk) begin
        res.sig    <= sum;
        res.sticky <= |sticky_m;    // Only unmasked terms count.
        res.exp    <= aln.max_exp;
    end

endmodule

// File: fedp_top.sv
module fedp_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 valid_in,
    input  fedp_pkg::fedp_req_t  req,
    output logic                 valid_out,
    output fedp_pkg::fedp_res_t  res,
    input  fedp_pkg::axil_req_t  axil_req,
    output fedp_pkg::axil_rsp_t  axil_rsp
);

    logic                            enable;
    logic [fedp_pkg::NUM_LANES-1:0]  lane_mask;
    fedp_pkg::fedp_prod_t            prod;
    fedp_pkg::fedp_aln_t             aln;

    // ########################################################
    // Register block.
    // ########################################################
    fedp_csr u_csr (
        .clk         (clk),
        .arst_n      (arst_n),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp),
        .result_done (valid_out),   // Counts every result.
        .enable      (enable),
        .lane_mask   (lane_mask)
    );

    // ########################################################
    // Three-stage datapath, one cycle each.
    // ########################################################
    fedp_mul u_mul (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid_in  (valid_in),
        .req       (req),
        .enable    (enable),
        .lane_mask (lane_mask),
        .prod      (prod)
    );

    fedp_align u_align (
        .clk    (clk),
        .arst_n (arst_n),
        .prod   (prod),
        .aln    (aln)
    );

    fedp_acc u_acc (
        .clk       (clk),
        .arst_n    (arst_n),
        .aln       (aln),
        .valid_out (valid_out),
        .res       (res)
    );

endmodule

// File: tb_fedp.sv
module tb_fedp;
    timeunit 1ns;
    timeprecision 1ps;

    logic                 clk;
    logic                 arst_n;
    logic                 valid_in;
    fedp_pkg::fedp_req_t  req;
    logic                 valid_out;
    fedp_pkg::fedp_res_t  res;
    fedp_pkg::axil_req_t  axil_req;
    fedp_pkg::axil_rsp_t  axil_rsp;

    int                              n_val;      // Wrong values.
    int                              n_proto;    // Timeouts, missing or extra results.
    int                              n_acc;      // Requests the DUT should accept.
    int                              cyc;        // Rising edges so far.
    int                              seed;
    int                              wait_max;
    logic                            cur_en;
    logic [fedp_pkg::NUM_LANES-1:0]  cur_mask;   // Mirror of CTRL mask.

    fedp_pkg::fedp_req_t             tab_req[$];
    logic [fedp_pkg::NUM_LANES-1:0]  tab_mask[$];
    string                           tab_name[$];

    fedp_pkg::fedp_res_t             exp_q[$];   // Scoreboard.
    string                           name_q[$];
    int                              edge_q[$];  // Edge just before each request's input cycle.

    fedp_top DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid_in  (valid_in),
        .req       (req),
        .valid_out (valid_out),
        .res       (res),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // ########################################################
    // Reference model and compare tasks.
    // ########################################################
    function automatic fedp_pkg::fedp_res_t model(input fedp_pkg::fedp_req_t r,
                                                  input logic [fedp_pkg::NUM_LANES-1:0] mask);
        longint              val[fedp_pkg::NUM_TERMS];
        int                  e[fedp_pkg::NUM_TERMS];
        int                  mx;
        longint              sh;
        longint              sum;
        logic                stk;
        fedp_pkg::fedp_res_t o;
        for (int i = 0; i < fedp_pkg::NUM_LANES; i++) begin
            val[i] = longint'($signed(r.a[i])) * longint'($signed(r.b[i]));
            e[i]   = r.a_exp[i] + r.b_exp[i];
        end
        val[fedp_pkg::NUM_LANES] = longint'($signed(r.c));   // C term last.
        e[fedp_pkg::NUM_LANES]   = r.c_exp;
        mx = 0;
        for (int i = 0; i < fedp_pkg::NUM_TERMS; i++) begin
            if (e[i] > mx) begin
                mx = e[i];   // Masked too.
            end
        end
        sum = 0;
        stk = 1'b0;
        for (int i = 0; i < fedp_pkg::NUM_TERMS; i++) begin
            sh = (val[i] <<< fedp_pkg::GUARD_W) >>> (mx - e[i]);
            if (i == fedp_pkg::NUM_LANES || mask[i]) begin
                sum += sh;
                // Lost bits show up as a mismatch after shifting back.
                if ((sh <<< (mx - e[i])) != (val[i] <<< fedp_pkg::GUARD_W)) stk = 1'b1;
            end
        end
        o.sig    = sum[fedp_pkg::ACC_W-1:0];
        o.sticky = stk;
        o.exp    = mx[fedp_pkg::CEXP_W-1:0];
        return o;
    endfunction

    task automatic check_res(input string name, input fedp_pkg::fedp_res_t e,
                             input fedp_pkg::fedp_res_t a);
        if (a !== e) begin
            n_val++;
            $write("ERROR %s: expected sig=%0d sticky=%0b exp=%0d,",
                   name, e.sig, e.sticky, e.exp);
            $display(" actual sig=%0d sticky=%0b exp=%0d", a.sig, a.sticky, a.exp);
        end
    endtask

    task automatic check_word(input string name, input logic [fedp_pkg::AXI_DATA_W-1:0] e,
                              input logic [fedp_pkg::AXI_DATA_W-1:0] a);
        if (a !== e) begin
            n_val++;
            $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, e, a);
        end
    endtask

    // Results sampled mid-cycle away from the edge.
    always @(negedge clk) begin
        if (arst_n && valid_out) begin
            if (exp_q.size() == 0) begin
                n_proto++;
                $display("Unexpected valid_out at cycle %0d with no request pending.", cyc);
            end else begin
                if (cyc != edge_q[0] + 3) begin
                    n_proto++;
                    $display("Result for %s came at cycle %0d instead of %0d.",
                             name_q[0], cyc, edge_q[0] + 3);
                end
                check_res(name_q[0], exp_q[0], res);
                exp_q.delete(0);
                name_q.delete(0);
                edge_q.delete(0);
            end
        end
    end

    // ########################################################
    // AXI4-Lite and datapath drivers.
    // ########################################################
    task automatic axil_write(input logic [fedp_pkg::AXI_ADDR_W-1:0] addr,
                              input logic [fedp_pkg::AXI_DATA_W-1:0] data);
        int t;
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = '1;
        axil_req.bready  = 1'b1;
        t = 0;
        while (!(axil_rsp.awready && axil_rsp.wready) && t < wait_max) begin
            @(negedge clk);
            t++;
        end
        if (!(axil_rsp.awready && axil_rsp.wready)) begin
            n_proto++;
            $display("AXI write to 0x%h never saw awready and wready together.", addr);
        end
        @(posedge clk);
        #1;
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        t = 0;
        while (!axil_rsp.bvalid && t < wait_max) begin
            @(negedge clk);
            t++;
        end
        if (!axil_rsp.bvalid) begin
            n_proto++;
            $display("AXI write to 0x%h never got a response.", addr);
        end
        check_word("bresp", 32'h0, 32'(axil_rsp.bresp));
        @(posedge clk);
        #1;
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [fedp_pkg::AXI_ADDR_W-1:0] addr,
                             output logic [fedp_pkg::AXI_DATA_W-1:0] data);
        int t;
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        axil_req.rready  = 1'b1;
        t = 0;
        while (!axil_rsp.arready && t < wait_max) begin
            @(negedge clk);
            t++;
        end
        if (!axil_rsp.arready) begin
            n_proto++;
            $display("AXI read of 0x%h never saw arready.", addr);
        end
        @(posedge clk);
        #1;
        axil_req.arvalid = 1'b0;
        t = 0;
        while (!axil_rsp.rvalid && t < wait_max) begin
            @(negedge clk);
            t++;
        end
        if (!axil_rsp.rvalid) begin
            n_proto++;
            $display("AXI read of 0x%h never returned data.", addr);
        end
        check_word("rresp", 32'h0, 32'(axil_rsp.rresp));
        data = axil_rsp.rdata;
        @(posedge clk);
        #1;
        axil_req.rready = 1'b0;
    endtask

    // Write CTRL and read it back.
    task automatic set_ctrl(input logic en, input logic [fedp_pkg::NUM_LANES-1:0] mask);
        logic [fedp_pkg::AXI_DATA_W-1:0] word;
        logic [fedp_pkg::AXI_DATA_W-1:0] rd;
        word = {24'h0, mask, 3'b000, en};
        axil_write(fedp_pkg::ADDR_CTRL, word);
        axil_read(fedp_pkg::ADDR_CTRL, rd);
        check_word("ctrl_readback", word, rd);
        cur_en   = en;
        cur_mask = mask;
    endtask

    // One request for one cycle; back-to-back calls keep valid_in high.
    task automatic send(input fedp_pkg::fedp_req_t r, input string name);
        req      = r;
        valid_in = 1'b1;
        if (cur_en) begin
            exp_q.push_back(model(r, cur_mask));
            name_q.push_back(name);
            edge_q.push_back(cyc);
            n_acc++;
        end
        @(posedge clk);
        #1;
        valid_in = 1'b0;
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < wait_max) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (exp_q.size() != 0) begin
            n_proto++;
            $display("Missing valid_out for %0d requests, first %s.", exp_q.size(), name_q[0]);
            exp_q.delete();
            name_q.delete();
            edge_q.delete();
        end
    endtask

    task automatic add_row(input string name, input logic [31:0] a, input logic [31:0] b,
                           input logic [15:0] ae, input logic [15:0] be, input logic [15:0] c,
                           input logic [4:0] ce, input logic [3:0] mask);
        fedp_pkg::fedp_req_t r;
        r.a     = a;
        r.b     = b;
        r.a_exp = ae;
        r.b_exp = be;
        r.c     = c;
        r.c_exp = ce;
        tab_req.push_back(r);
        tab_mask.push_back(mask);
        tab_name.push_back(name);
    endtask

    // ########################################################
    // Test sequence.
    // ########################################################
    initial begin
        logic [fedp_pkg::AXI_DATA_W-1:0] rd;
        logic [127:0]                    blk;
        clk      = 1'b0;
        arst_n   = 1'b0;
        valid_in = 1'b0;
        req      = '0;
        axil_req = '0;
        n_val    = 0;
        n_proto  = 0;
        n_acc    = 0;
        cyc      = 0;
        seed     = 85;
        wait_max = 100;
        cur_en   = 1'b1;
        cur_mask = '1;

        // Lane bytes listed as {lane3, lane2, lane1, lane0}.
        add_row("small_equal",   32'h04030201, 32'h08070605, 16'h0000, 16'h0000, 16'd100, 5'd0, 4'hF);
        add_row("neg_products",  32'hFFFE85F6, 32'h7F0304F6, 16'h2222, 16'h1111, 16'hFF00, 5'd3, 4'hF);
        add_row("min_times_min", 32'h80808080, 32'h80808080, 16'h0000, 16'h0000, 16'h8000, 5'd0, 4'hF);
        add_row("small_gaps",    32'h7F8110F0, 32'h7F7FF010, 16'h4321, 16'h1000, 16'h0123, 5'd4, 4'hF);
        add_row("gap_sticky",    32'h03050709, 32'h01010101, 16'hF000, 16'h0000, 16'h0400, 5'd12, 4'hF);
        add_row("gap_saturate",  32'h10F08001, 32'h01010101, 16'h0000, 16'h0000, 16'h4000, 5'd31, 4'hF);
        add_row("gap_26",        32'h7F80C005, 32'h7F7F0333, 16'h0000, 16'h0000, 16'h0001, 5'd26, 4'hF);
        add_row("mask_0101",     32'h11223344, 32'h02020202, 16'h0000, 16'h0000, 16'd7, 5'd0, 4'h5);
        add_row("mask_1000_gap", 32'h807F0102, 32'hF0102030, 16'h3000, 16'h3000, 16'hFFFF, 5'd9, 4'h8);
        add_row("mask_none",     32'h55667788, 32'h99AABBCC, 16'h0F00, 16'h0F00, 16'h1234, 5'd2, 4'h0);

        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Reset state.
        if (valid_out !== 1'b0) begin
            n_proto++;
            $display("valid_out is not low after reset.");
        end
        axil_read(fedp_pkg::ADDR_CTRL, rd);
        check_word("ctrl_reset", fedp_pkg::CTRL_RESET, rd);
        axil_read(fedp_pkg::ADDR_COUNT, rd);
        check_word("count_reset", 32'h0, rd);

        // Table rows go back to back while the mask stays put.
        for (int i = 0; i < tab_name.size(); i++) begin
            if (tab_mask[i] != cur_mask) set_ctrl(1'b1, tab_mask[i]);
            send(tab_req[i], tab_name[i]);
        end
        drain();
        axil_read(fedp_pkg::ADDR_COUNT, rd);
        check_word("count_after_table", 32'(n_acc), rd);

        // Disabled requests give nothing and COUNT holds.
        set_ctrl(1'b0, 4'hF);
        for (int i = 0; i < 5; i++) send(tab_req[i], "disabled");
        for (int t = 0; t < 20; t++) @(posedge clk);   // Quiet window.
        #1;
        axil_read(fedp_pkg::ADDR_COUNT, rd);
        check_word("count_disabled", 32'(n_acc), rd);

        // Random requests with a new random mask every 50.
        for (int k = 0; k < 200; k++) begin
            if (k % 50 == 0) set_ctrl(1'b1, 4'($random(seed)));
            blk = {$random(seed), $random(seed), $random(seed), $random(seed)};
            send(blk[$bits(fedp_pkg::fedp_req_t)-1:0], $sformatf("random_%0d", k));
        end
        drain();
        axil_read(fedp_pkg::ADDR_COUNT, rd);
        check_word("count_final", 32'(n_acc), rd);

        $display("Errors: %0d value, %0d protocol.", n_val, n_proto);
        if (n_val + n_proto == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
fedp_pkg.sv
fedp_csr.sv
fedp_mul.sv
fedp_align.sv
fedp_acc.sv
fedp_top.sv
tb_fedp.sv
